// ==== rtl/udp_pkg.sv ====
package udp_pkg;

    // Multi-byte addresses keep the first byte on the wire in bits 7:0
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [4:0]  reg_addr_t;    // Byte address
    typedef logic [31:0] reg_data_t;
    typedef logic [63:0] axis_data_t;
    typedef logic [7:0]  axis_keep_t;
    typedef logic [4:0]  word_index_t;  // 0 to FRAME_WORDS-1

    typedef enum logic {
        SEQ_IDLE,
        SEQ_SEND
    } seq_state_t;

    // Frame geometry
    localparam int FRAME_WORDS       = 22;
    localparam int HEADER_BYTES      = 42;  // Ethernet 14 + IPv4 20 + UDP 8
    localparam int PAYLOAD_HALFWORDS = 64;
    localparam axis_keep_t LAST_KEEP = 8'h03;  // 170 bytes leave 2 in the last word
    localparam axis_keep_t FULL_KEEP = 8'hFF;

    // Register map
    localparam reg_addr_t ADDR_SENT_COUNT = 5'h00;
    localparam reg_addr_t ADDR_TIMER      = 5'h04;
    localparam reg_addr_t ADDR_DELAY      = 5'h08;
    localparam reg_addr_t ADDR_DST_MAC_LO = 5'h0C;
    localparam reg_addr_t ADDR_DST_MAC_HI = 5'h10;
    localparam reg_addr_t ADDR_SRC_IP     = 5'h14;
    localparam reg_addr_t ADDR_DST_IP     = 5'h18;

    // Fixed header fields, numeric values
    localparam mac_t        SRC_MAC        = 48'h5E_4D_3C_2B_1A_00;  // 00:1A:2B:3C:4D:5E
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [15:0] IP_TOTAL_LEN   = 16'd156;
    localparam logic [15:0] IP_IDENT       = 16'd1;
    localparam logic [15:0] IP_FLAGS_FRAG  = 16'h4000;  // Don't fragment
    localparam logic [7:0]  IP_TTL         = 8'd255;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] UDP_PORT       = 16'd60133;
    localparam logic [15:0] UDP_LEN        = 16'd136;
    localparam logic [15:0] UDP_CHECKSUM   = 16'h0000;

    localparam mac_t  RST_DST_MAC = 48'hFFFF_FFFF_FFFF;
    localparam ipv4_t RST_SRC_IP  = 32'h6304_A8C0;  // 192.168.4.99
    localparam ipv4_t RST_DST_IP  = 32'h0104_A8C0;  // 192.168.4.1

endpackage

// ==== rtl/udp_ctrl_regs.sv ====
`timescale 1ns/1ps

module udp_ctrl_regs #(
    parameter udp_pkg::reg_data_t reset_delay = 32'd10_000_000
) (
    input  logic                m00_axis_aclk,
    input  logic                m00_axis_aresetn,
    input  logic                reg_wr_en,
    input  logic                reg_rd_en,
    input  udp_pkg::reg_addr_t  reg_addr,
    input  udp_pkg::reg_data_t  reg_wdata,
    input  logic                packet_sent,
    input  udp_pkg::reg_data_t  timer_count,
    output udp_pkg::reg_data_t  reg_rdata,
    output logic                reg_rvalid,
    output udp_pkg::reg_data_t  packet_delay,
    output udp_pkg::mac_t       dst_mac,
    output udp_pkg::ipv4_t      src_ip,
    output udp_pkg::ipv4_t      dst_ip
);

    import udp_pkg::*;

    reg_data_t sent_count;
    reg_data_t rd_mux;

    // Writable fields
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            packet_delay <= reset_delay;
            dst_mac      <= RST_DST_MAC;
            src_ip       <= RST_SRC_IP;
            dst_ip       <= RST_DST_IP;
        end else if (reg_wr_en) begin
            case (reg_addr)
                ADDR_DELAY:      packet_delay   <= reg_wdata;
                ADDR_DST_MAC_LO: dst_mac[47:16] <= reg_wdata;  // MAC bytes 2..5
                ADDR_DST_MAC_HI: dst_mac[15:0]  <= reg_wdata[15:0];
                ADDR_SRC_IP:     src_ip         <= reg_wdata;
                ADDR_DST_IP:     dst_ip         <= reg_wdata;
                default: ;  // Read-only or unmapped
            endcase
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            sent_count <= '0;
        end else if (packet_sent) begin
            sent_count <= sent_count + 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            ADDR_SENT_COUNT: rd_mux = sent_count;
            ADDR_TIMER:      rd_mux = timer_count;
            ADDR_DELAY:      rd_mux = packet_delay;
            ADDR_DST_MAC_LO: rd_mux = dst_mac[47:16];
            ADDR_DST_MAC_HI: rd_mux = {16'h0000, dst_mac[15:0]};
            ADDR_SRC_IP:     rd_mux = src_ip;
            ADDR_DST_IP:     rd_mux = dst_ip;
            default:         rd_mux = '0;
        endcase
    end

    // Read data lands together with the valid pulse
    always_ff @(posedge m00_axis_aclk) begin
        if (reg_rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd_en;  // One cycle per request
        end
    end

endmodule

// ==== rtl/ipv4_checksum.sv ====
`timescale 1ns/1ps

module ipv4_checksum (
    input  logic            m00_axis_aclk,
    input  logic            m00_axis_aresetn,
    input  udp_pkg::ipv4_t  src_ip,
    input  udp_pkg::ipv4_t  dst_ip,
    output logic [15:0]     ip_checksum
);

    import udp_pkg::*;

    // Ten header words, checksum field counted as zero
    function automatic logic [15:0] header_checksum(input ipv4_t src, input ipv4_t dst);
        logic [19:0] sum;
        sum = 20'({IP_VER_IHL, 8'h00})        // TOS is 0
            + 20'(IP_TOTAL_LEN)
            + 20'(IP_IDENT)
            + 20'(IP_FLAGS_FRAG)
            + 20'({IP_TTL, IP_PROTO_UDP})
            + 20'({src[7:0], src[15:8]})      // Octets go out first octet first
            + 20'({src[23:16], src[31:24]})
            + 20'({dst[7:0], dst[15:8]})
            + 20'({dst[23:16], dst[31:24]});
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);  // End-around carry
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);  // Second fold catches its own carry
        return ~sum[15:0];
    endfunction

    localparam logic [15:0] RST_CHECKSUM = header_checksum(RST_SRC_IP, RST_DST_IP);

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            ip_checksum <= RST_CHECKSUM;
        end else begin
            ip_checksum <= header_checksum(src_ip, dst_ip);
        end
    end

endmodule

// ==== rtl/udp_frame_builder.sv ====
`timescale 1ns/1ps

module udp_frame_builder (
    input  udp_pkg::word_index_t  word_index,
    input  udp_pkg::mac_t         dst_mac,
    input  udp_pkg::ipv4_t        src_ip,
    input  udp_pkg::ipv4_t        dst_ip,
    input  logic [15:0]           ip_checksum,
    output udp_pkg::axis_data_t   frame_word
);

    import udp_pkg::*;

    localparam int HEADER_BITS = 8 * HEADER_BYTES;
    localparam int PAYLOAD_END = HEADER_BYTES + 2 * PAYLOAD_HALFWORDS;

    // Frame byte n sits at bits 8n and up
    logic [HEADER_BITS-1:0] header_bytes;

    // Puts a 16-bit field into byte order on the wire
    function automatic logic [15:0] be16(input logic [15:0] value);
        return {value[7:0], value[15:8]};
    endfunction

    function automatic logic [7:0] frame_byte(input logic [HEADER_BITS-1:0] hdr,
                                              input logic [7:0] n);
        logic [7:0]  p;
        logic [5:0]  k;
        logic [15:0] half;
        p    = n - 8'(HEADER_BYTES);
        k    = p[6:1];  // Payload half-word index
        half = k[0] ? 16'(8'd255 - 8'(k[5:1])) : 16'(k[5:1]);
        if (n < 8'(HEADER_BYTES)) begin
            return hdr[8*n +: 8];
        end else if (n < 8'(PAYLOAD_END)) begin
            return p[0] ? half[15:8] : half[7:0];  // Half-word stored low byte first
        end else begin
            return 8'h00;  // Tail of word 21
        end
    endfunction

    always_comb begin
        header_bytes = '0;
        // Ethernet
        header_bytes[0   +: 48] = dst_mac;
        header_bytes[48  +: 48] = SRC_MAC;
        header_bytes[96  +: 16] = be16(ETHERTYPE_IPV4);
        // IPv4 from byte 14
        header_bytes[112 +: 8]  = IP_VER_IHL;
        header_bytes[120 +: 8]  = 8'h00;
        header_bytes[128 +: 16] = be16(IP_TOTAL_LEN);
        header_bytes[144 +: 16] = be16(IP_IDENT);
        header_bytes[160 +: 16] = be16(IP_FLAGS_FRAG);
        header_bytes[176 +: 8]  = IP_TTL;
        header_bytes[184 +: 8]  = IP_PROTO_UDP;
        header_bytes[192 +: 16] = be16(ip_checksum);
        header_bytes[208 +: 32] = src_ip;  // Already in octet order
        header_bytes[240 +: 32] = dst_ip;
        // UDP from byte 34
        header_bytes[272 +: 16] = be16(UDP_PORT);
        header_bytes[288 +: 16] = be16(UDP_PORT);
        header_bytes[304 +: 16] = be16(UDP_LEN);
        header_bytes[320 +: 16] = be16(UDP_CHECKSUM);
    end

    for (genvar lane = 0; lane < 8; lane++) begin : g_lane
        assign frame_word[8*lane +: 8] = frame_byte(header_bytes, {word_index, 3'(lane)});
    end

endmodule

// ==== rtl/udp_stream_sequencer.sv ====
`timescale 1ns/1ps

module udp_stream_sequencer (
    input  logic                  m00_axis_aclk,
    input  logic                  m00_axis_aresetn,
    input  udp_pkg::reg_data_t    packet_delay,
    input  logic                  m00_axis_tready,
    input  udp_pkg::axis_data_t   frame_word,
    output udp_pkg::word_index_t  word_index,
    output logic                  m00_axis_tvalid,
    output udp_pkg::axis_data_t   m00_axis_tdata,
    output udp_pkg::axis_keep_t   m00_axis_tkeep,
    output logic                  m00_axis_tlast,
    output logic                  packet_sent,
    output udp_pkg::reg_data_t    timer_count
);

    import udp_pkg::*;

    localparam word_index_t LAST_WORD = word_index_t'(FRAME_WORDS - 1);

    seq_state_t state;
    logic       trigger;
    logic       last_word;
    logic       beat;

    // Period timer, a delay of 0 keeps it free-running with no trigger
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            timer_count <= '0;
            trigger     <= 1'b0;
        end else if (packet_delay != '0 && timer_count >= packet_delay) begin
            timer_count <= '0;  // >= also recovers when the period is shortened
            trigger     <= 1'b1;
        end else begin
            timer_count <= timer_count + 1'b1;
            trigger     <= 1'b0;
        end
    end

    assign last_word = (word_index == LAST_WORD);
    assign beat      = m00_axis_tvalid && m00_axis_tready;

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            state      <= SEQ_IDLE;
            word_index <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (trigger) begin
                        state      <= SEQ_SEND;
                        word_index <= '0;
                    end
                end
                SEQ_SEND: begin  // Triggers are ignored here
                    if (beat) begin
                        if (last_word) begin
                            state      <= SEQ_IDLE;
                            word_index <= '0;
                        end else begin
                            word_index <= word_index + 1'b1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // All outputs follow registered state, so they hold under back-pressure
    assign m00_axis_tvalid = (state == SEQ_SEND);
    assign m00_axis_tlast  = m00_axis_tvalid && last_word;
    assign m00_axis_tkeep  = !m00_axis_tvalid ? '0 : (last_word ? LAST_KEEP : FULL_KEEP);
    assign m00_axis_tdata  = frame_word;
    assign packet_sent     = beat && last_word;

endmodule

// ==== rtl/udp_stream_top.sv ====
`timescale 1ns/1ps

module udp_stream_top #(
    parameter udp_pkg::reg_data_t reset_delay = 32'd10_000_000
) (
    input  logic                 m00_axis_aclk,
    input  logic                 m00_axis_aresetn,
    input  logic                 m00_axis_tready,
    input  logic                 reg_wr_en,
    input  logic                 reg_rd_en,
    input  udp_pkg::reg_addr_t   reg_addr,
    input  udp_pkg::reg_data_t   reg_wdata,
    output logic                 m00_axis_tvalid,
    output udp_pkg::axis_data_t  m00_axis_tdata,
    output udp_pkg::axis_keep_t  m00_axis_tkeep,
    output logic                 m00_axis_tlast,
    output udp_pkg::reg_data_t   reg_rdata,
    output logic                 reg_rvalid
);

    import udp_pkg::*;

    reg_data_t   packet_delay;
    reg_data_t   timer_count;
    mac_t        dst_mac;
    ipv4_t       src_ip;
    ipv4_t       dst_ip;
    logic [15:0] ip_checksum;
    word_index_t word_index;
    axis_data_t  frame_word;
    logic        packet_sent;

    udp_ctrl_regs #(
        .reset_delay (reset_delay)
    ) u_regs (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .reg_wr_en        (reg_wr_en),
        .reg_rd_en        (reg_rd_en),
        .reg_addr         (reg_addr),
        .reg_wdata        (reg_wdata),
        .packet_sent      (packet_sent),
        .timer_count      (timer_count),
        .reg_rdata        (reg_rdata),
        .reg_rvalid       (reg_rvalid),
        .packet_delay     (packet_delay),
        .dst_mac          (dst_mac),
        .src_ip           (src_ip),
        .dst_ip           (dst_ip)
    );

    ipv4_checksum u_checksum (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .src_ip           (src_ip),
        .dst_ip           (dst_ip),
        .ip_checksum      (ip_checksum)
    );

    udp_frame_builder u_builder (
        .word_index  (word_index),
        .dst_mac     (dst_mac),
        .src_ip      (src_ip),
        .dst_ip      (dst_ip),
        .ip_checksum (ip_checksum),
        .frame_word  (frame_word)
    );

    udp_stream_sequencer u_sequencer (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .packet_delay     (packet_delay),
        .m00_axis_tready  (m00_axis_tready),
        .frame_word       (frame_word),
        .word_index       (word_index),
        .m00_axis_tvalid  (m00_axis_tvalid),
        .m00_axis_tdata   (m00_axis_tdata),
        .m00_axis_tkeep   (m00_axis_tkeep),
        .m00_axis_tlast   (m00_axis_tlast),
        .packet_sent      (packet_sent),
        .timer_count      (timer_count)
    );

endmodule

// ==== verif/udp_stream_assertions.sv ====
`timescale 1ns/1ps

module udp_stream_assertions (
    input logic                 m00_axis_aclk,
    input logic                 m00_axis_aresetn,
    input logic                 m00_axis_tready,
    input logic                 m00_axis_tvalid,
    input udp_pkg::axis_data_t  m00_axis_tdata,
    input udp_pkg::axis_keep_t  m00_axis_tkeep,
    input logic                 m00_axis_tlast,
    input logic                 reg_rd_en,
    input logic                 reg_rvalid
);

    import udp_pkg::*;

    // A stalled beat stays put until the sink takes it
    stall_holds: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        (m00_axis_tvalid && !m00_axis_tready) |=> (m00_axis_tvalid && $stable(m00_axis_tdata)
            && $stable(m00_axis_tkeep) && $stable(m00_axis_tlast)))
        else $error("stalled beat changed before it was accepted");

    last_keep: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tlast |-> (m00_axis_tkeep == LAST_KEEP))
        else $error("tlast beat carries the wrong tkeep");

    keep_nonzero: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tvalid |-> (m00_axis_tkeep != '0))
        else $error("valid beat with no byte enabled");

    // Read valid comes one cycle after the request and only then
    rvalid_follows: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        reg_rd_en |=> reg_rvalid)
        else $error("read request got no read valid");

    rvalid_requested: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        reg_rvalid |-> $past(reg_rd_en))
        else $error("read valid without a read request");

    rvalid_single: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        reg_rvalid |=> !reg_rvalid)
        else $error("read valid held for two cycles");

endmodule

bind udp_stream_top udp_stream_assertions u_assertions (.*);

// ==== verif/tb_udp_stream.sv ====
`timescale 1ns/1ps

module tb_udp_stream;

    import udp_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PERIOD_CYCLES  = 400;

    logic        m00_axis_aclk;
    logic        m00_axis_aresetn;
    logic        m00_axis_tready;
    logic        reg_wr_en;
    logic        reg_rd_en;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    logic        m00_axis_tvalid;
    axis_data_t  m00_axis_tdata;
    axis_keep_t  m00_axis_tkeep;
    logic        m00_axis_tlast;
    reg_data_t   reg_rdata;
    logic        reg_rvalid;

    // Shadow copies of the writable registers
    reg_data_t   exp_delay;
    reg_data_t   exp_mac_lo;
    reg_data_t   exp_mac_hi;
    reg_data_t   exp_src_ip;
    reg_data_t   exp_dst_ip;
    logic [7:0]  hdr [HEADER_BYTES];  // Expected header, wire order
    int          frames_sent;
    reg_data_t   rd_value;
    int          edges_out_of_reset;  // Rising edges since reset release

    udp_stream_top dut (.*);

    always #20 m00_axis_aclk = ~m00_axis_aclk;

    // The timer counts every cycle once reset is gone
    always @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            edges_out_of_reset <= 0;
        end else begin
            edges_out_of_reset <= edges_out_of_reset + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic put16(input int pos, input logic [15:0] value);
        hdr[pos]     = value[15:8];  // Network byte order
        hdr[pos + 1] = value[7:0];
    endtask

    // Header from the shadow registers, checksum filled in last
    task automatic build_header();
        logic [47:0] src_mac;
        logic [31:0] sum;
        src_mac = 48'h001A_2B3C_4D5E;
        for (int i = 0; i < 2; i++) begin
            hdr[i] = exp_mac_hi[8*i +: 8];
        end
        for (int i = 0; i < 4; i++) begin
            hdr[2 + i] = exp_mac_lo[8*i +: 8];
        end
        for (int i = 0; i < 6; i++) begin
            hdr[6 + i] = src_mac[40 - 8*i +: 8];
        end
        put16(12, 16'h0800);
        put16(14, 16'h4500);  // Version, IHL and TOS
        put16(16, 16'd156);
        put16(18, 16'd1);
        put16(20, 16'h4000);
        put16(22, {8'd255, 8'd17});
        put16(24, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            hdr[26 + i] = exp_src_ip[8*i +: 8];
            hdr[30 + i] = exp_dst_ip[8*i +: 8];
        end
        put16(34, 16'd60133);
        put16(36, 16'd60133);
        put16(38, 16'd136);
        put16(40, 16'h0000);
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + {16'h0000, hdr[i], hdr[i + 1]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        put16(24, ~sum[15:0]);
    endtask

    function automatic axis_data_t model_word(input int w);
        axis_data_t word;
        int         n;
        int         k;
        int         half;
        for (int lane = 0; lane < 8; lane++) begin
            n    = 8 * w + lane;
            k    = (n - 42) / 2;  // Payload half-word
            half = (k % 2 == 0) ? k / 2 : 255 - k / 2;
            if (n < 42) begin
                word[8*lane +: 8] = hdr[n];
            end else if (n < 170) begin
                word[8*lane +: 8] = ((n - 42) % 2 == 0) ? half[7:0] : half[15:8];
            end else begin
                word[8*lane +: 8] = 8'h00;
            end
        end
        return word;
    endfunction

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(negedge m00_axis_aclk);
        reg_wr_en = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge m00_axis_aclk);
        reg_wr_en = 1'b0;
        case (addr)
            ADDR_DELAY:      exp_delay  = data;
            ADDR_DST_MAC_LO: exp_mac_lo = data;
            ADDR_DST_MAC_HI: exp_mac_hi = {16'h0000, data[15:0]};
            ADDR_SRC_IP:     exp_src_ip = data;
            ADDR_DST_IP:     exp_dst_ip = data;
            default: ;
        endcase
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        int cycles;
        @(negedge m00_axis_aclk);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        @(negedge m00_axis_aclk);
        reg_rd_en = 1'b0;
        cycles    = 0;
        while (!reg_rvalid) begin
            if (cycles == TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for reg_rvalid");
            end
            cycles++;
            @(negedge m00_axis_aclk);
        end
        data = reg_rdata;
    endtask

    task automatic expect_read(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_data_t value;
        read_reg(addr, value);
        compare_value(name, 64'(value), 64'(exp));
    endtask

    task automatic verify_registers();
        expect_read(ADDR_DELAY, exp_delay, "delay register");
        expect_read(ADDR_DST_MAC_LO, exp_mac_lo, "dst mac lo register");
        expect_read(ADDR_DST_MAC_HI, exp_mac_hi, "dst mac hi register");
        expect_read(ADDR_SRC_IP, exp_src_ip, "src ip register");
        expect_read(ADDR_DST_IP, exp_dst_ip, "dst ip register");
    endtask

    // Checks every accepted beat of one frame, tready set each falling edge
    task automatic capture_frame(input bit random_ready);
        int w;
        int cycles;
        w      = 0;
        cycles = 0;
        build_header();
        while (w < FRAME_WORDS) begin
            @(negedge m00_axis_aclk);
            m00_axis_tready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
            if (m00_axis_tvalid && m00_axis_tready) begin
                compare_value("m00_axis_tdata", m00_axis_tdata, model_word(w));
                compare_value("m00_axis_tkeep", 64'(m00_axis_tkeep),
                              (w == FRAME_WORDS - 1) ? 64'h03 : 64'hFF);
                compare_value("m00_axis_tlast", 64'(m00_axis_tlast), 64'(w == FRAME_WORDS - 1));
                w++;
                cycles = 0;
            end else begin
                cycles++;
                if (cycles == TIMEOUT_CYCLES) begin
                    abort_run("timeout waiting for a stream beat");
                end
            end
        end
        frames_sent++;
    endtask

    initial begin
        void'($urandom(32'h124f));
        m00_axis_aclk    = 1'b0;
        m00_axis_aresetn = 1'b0;
        m00_axis_tready  = 1'b1;
        reg_wr_en        = 1'b0;
        reg_rd_en        = 1'b0;
        reg_addr         = '0;
        reg_wdata        = '0;
        exp_delay        = 32'd10_000_000;
        exp_mac_lo       = 32'hFFFF_FFFF;
        exp_mac_hi       = 32'h0000_FFFF;
        exp_src_ip       = 32'h6304_A8C0;  // 192.168.4.99
        exp_dst_ip       = 32'h0104_A8C0;  // 192.168.4.1
        frames_sent      = 0;
        repeat (10) @(negedge m00_axis_aclk);
        m00_axis_aresetn = 1'b1;

        compare_value("m00_axis_tvalid", 64'(m00_axis_tvalid), 64'h0);
        compare_value("m00_axis_tkeep", 64'(m00_axis_tkeep), 64'h0);
        compare_value("reg_rvalid", 64'(reg_rvalid), 64'h0);
        verify_registers();
        expect_read(ADDR_SENT_COUNT, 32'd0, "sent count");
        expect_read(5'h1C, 32'd0, "unmapped register");
        read_reg(ADDR_TIMER, rd_value);
        // Sampled on the edge before the one just counted
        compare_value("timer register", 64'(rd_value), 64'(edges_out_of_reset - 1));

        // Period kept far above the timer so no frame starts yet
        write_reg(ADDR_DELAY, $urandom() | 32'h8000_0000);
        write_reg(ADDR_DST_MAC_LO, $urandom());
        write_reg(ADDR_DST_MAC_HI, $urandom());
        write_reg(ADDR_SRC_IP, $urandom());
        write_reg(ADDR_DST_IP, $urandom());
        verify_registers();

        write_reg(ADDR_DELAY, 32'(PERIOD_CYCLES));
        capture_frame(1'b0);

        write_reg(ADDR_SRC_IP, $urandom());  // New checksum for the next frames
        write_reg(ADDR_DST_IP, $urandom());
        capture_frame(1'b1);
        capture_frame(1'b1);

        expect_read(ADDR_SENT_COUNT, 32'(frames_sent), "sent count");
        write_reg(ADDR_DELAY, 32'd0);
        repeat (3 * PERIOD_CYCLES) begin
            @(negedge m00_axis_aclk);
            compare_value("m00_axis_tvalid", 64'(m00_axis_tvalid), 64'h0);
        end
        expect_read(ADDR_SENT_COUNT, 32'(frames_sent), "sent count");

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/udp_pkg.sv
rtl/udp_ctrl_regs.sv
rtl/ipv4_checksum.sv
rtl/udp_frame_builder.sv
rtl/udp_stream_sequencer.sv
rtl/udp_stream_top.sv
verif/udp_stream_assertions.sv
verif/tb_udp_stream.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_udp_stream
FILELIST   := tb.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/1ps --top-module $(TOP)
VFLAGS     := --binary -j 0 --Mdir $(OBJ_DIR) $(COMMON)
LINT_FLAGS := --lint-only $(COMMON)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
